// ==== source/bank_sched_pkg.sv ====
//******************************
// Shared definitions for the bank scheduler
// Request field widths and the request struct
// Arbitration mode and scheduler state enums
//******************************

package bank_sched_pkg;

  //******************************
  // Field widths
  //******************************
  parameter int ROW_W = 8;  // Row, used as the burst tag
  parameter int COL_W = 4;  // Column inside the row

  // One queued request, row in the upper bits
  typedef struct packed {
    logic [ROW_W-1:0] row;  // Burst tag
    logic [COL_W-1:0] col;  // Column address
  } req_t;

  // Direction the scheduler drains, read keeps the 1 encoding
  typedef enum logic {
    MODE_WR = 1'b0,
    MODE_RD = 1'b1
  } mode_e;

  // Scheduler FSM
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,  // Nothing pending in the current mode
    ST_WAIT     = 3'd1,  // Leader ready, waiting on the arbiter
    ST_RD_BURST = 3'd2,  // Draining read row hits
    ST_WR_BURST = 3'd3,  // Draining write row hits
    ST_GAP      = 3'd4   // One idle cycle between bursts
  } sched_state_e;

endpackage

// ==== source/req_fifo.sv ====
//******************************
// Single request queue
// Circular buffer, head is the oldest entry
// Occupancy count with full and empty flags
//******************************

module req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push_i,   // Write strobe, dropped when full
  input  bank_sched_pkg::req_t            req_i,
  input  logic                            pop_i,    // Remove the head
  output bank_sched_pkg::req_t            head_o,   // Oldest entry
  output logic                            empty_o,
  output logic                            full_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o   // Entries held
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  bank_sched_pkg::req_t mem [FIFO_DEPTH];  // Entry storage
  logic [PTR_W-1:0] wr_ptr;                // Next free slot
  logic [PTR_W-1:0] rd_ptr;                // Head slot
  logic             do_push;
  logic             do_pop;

  // Wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push_i && !full_o;   // Full queue drops the push
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count_o == '0);
  assign full_o  = (count_o == CNT_W'(FIFO_DEPTH));
  assign head_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= req_i;
    end
  end

  //******************************
  // Pointers and occupancy
  //******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

// ==== source/wr_watermark.sv ====
//******************************
// Write watermark control
// Sums write queue occupancy
// Hysteresis between high and low marks
//******************************

module wr_watermark #(
  parameter int WR_FIFO_NUM = 3,
  parameter int FIFO_DEPTH  = 4,
  parameter int HI_WM       = 8,  // Enter write mode at or above
  parameter int LO_WM       = 3   // Leave write mode at or below
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [WR_FIFO_NUM-1:0][$clog2(FIFO_DEPTH+1)-1:0] wr_count_i,   // Per write queue
  input  logic                                              rd_pending_i, // Any read queued
  output bank_sched_pkg::mode_e                             mode_o
);

  localparam int SUM_W = $clog2(WR_FIFO_NUM * FIFO_DEPTH + 1);

  logic [SUM_W-1:0] wr_sum;  // Total write entries
  logic             go_wr;
  logic             go_rd;

  always_comb begin
    wr_sum = '0;
    for (int i = 0; i < WR_FIFO_NUM; i++) begin
      wr_sum = wr_sum + SUM_W'(wr_count_i[i]);
    end
  end

  // High mark hit, or writes waiting with no read to serve
  assign go_wr = (int'(wr_sum) >= HI_WM) || ((wr_sum != '0) && !rd_pending_i);
  // Back to reads once the write backlog has drained enough
  assign go_rd = rd_pending_i && (int'(wr_sum) <= LO_WM);

  //******************************
  // Mode register
  //******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_o <= bank_sched_pkg::MODE_RD;  // Reads first out of reset
    end else if (go_wr) begin
      mode_o <= bank_sched_pkg::MODE_WR;
    end else if (go_rd) begin
      mode_o <= bank_sched_pkg::MODE_RD;
    end
    // Otherwise hold
  end

endmodule

// ==== source/burst_sched.sv ====
//******************************
// Burst scheduler FSM
// Round-robin leader per direction
// Row-hit draining, one pop per cycle
// One-hot pop vector and burst direction
//******************************

module burst_sched #(
  parameter int RD_FIFO_NUM = 4,
  parameter int WR_FIFO_NUM = 3
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  ready_i,  // Arbiter level
  input  bank_sched_pkg::mode_e                                 mode_i,
  input  logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]                    empty_i,
  input  bank_sched_pkg::req_t [RD_FIFO_NUM+WR_FIFO_NUM-1:0]    head_i,
  output logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]                    pop_o,    // One-hot or zero
  output logic                                                  write_o   // Burst is a write
);

  localparam int FIFO_NUM = RD_FIFO_NUM + WR_FIFO_NUM;
  localparam int RD_PTR_W = (RD_FIFO_NUM > 1) ? $clog2(RD_FIFO_NUM) : 1;
  localparam int WR_PTR_W = (WR_FIFO_NUM > 1) ? $clog2(WR_FIFO_NUM) : 1;

  bank_sched_pkg::sched_state_e       state;
  bank_sched_pkg::sched_state_e       state_nxt;
  logic [bank_sched_pkg::ROW_W-1:0]   burst_row;  // Row of the current burst leader
  logic [RD_PTR_W-1:0]                rd_last;    // Last read leader, group relative
  logic [WR_PTR_W-1:0]                wr_last;    // Last write leader, group relative
  logic [FIFO_NUM-1:0]                busy;       // Queue holds a request
  logic [FIFO_NUM-1:0]                hits;       // Head matches the burst row
  logic                               rd_any;
  logic                               wr_any;
  logic                               mode_any;   // Current mode has work
  logic                               lead_pop;   // Leader issued this cycle
  int                                 lead_idx;
  int                                 hit_idx;

  // First busy queue after last, wrapping inside [base, base+num)
  function automatic int rr_pick(input logic [FIFO_NUM-1:0] vec, input int base,
                                 input int num, input int last);
    int idx;
    int pick;
    pick = base + last;
    for (int k = num; k >= 1; k--) begin  // Nearest offset assigned last
      idx = base + ((last + k) % num);
      if (vec[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  assign busy     = ~empty_i;
  assign rd_any   = |busy[RD_FIFO_NUM-1:0];
  assign wr_any   = |busy[FIFO_NUM-1:RD_FIFO_NUM];
  assign mode_any = (mode_i == bank_sched_pkg::MODE_RD) ? rd_any : wr_any;
  assign lead_idx = (mode_i == bank_sched_pkg::MODE_RD) ?
                    rr_pick(busy, 0, RD_FIFO_NUM, int'(rd_last)) :
                    rr_pick(busy, RD_FIFO_NUM, WR_FIFO_NUM, int'(wr_last));

  // Direction of whatever pops this cycle
  assign write_o = (state == bank_sched_pkg::ST_WR_BURST) ||
                   ((state == bank_sched_pkg::ST_WAIT) && (mode_i == bank_sched_pkg::MODE_WR));

  //******************************
  // Row hits, same group only
  //******************************
  always_comb begin
    hits    = '0;
    hit_idx = 0;
    for (int i = 0; i < FIFO_NUM; i++) begin
      hits[i] = busy[i] && (head_i[i].row == burst_row) &&
                ((i >= RD_FIFO_NUM) == (state == bank_sched_pkg::ST_WR_BURST));
    end
    for (int i = FIFO_NUM - 1; i >= 0; i--) begin  // Lowest index wins
      if (hits[i]) begin
        hit_idx = i;
      end
    end
  end

  //******************************
  // Next state and pops
  //******************************
  always_comb begin
    state_nxt = state;
    pop_o     = '0;
    lead_pop  = 1'b0;
    case (state)
      bank_sched_pkg::ST_IDLE: begin
        if (mode_any) begin
          state_nxt = bank_sched_pkg::ST_WAIT;
        end
      end
      bank_sched_pkg::ST_WAIT: begin
        if (!mode_any) begin
          state_nxt = bank_sched_pkg::ST_IDLE;  // Mode flipped to an empty group
        end else if (ready_i) begin             // Ready only sampled here
          pop_o[lead_idx] = 1'b1;
          lead_pop        = 1'b1;
          state_nxt       = (mode_i == bank_sched_pkg::MODE_RD) ?
                            bank_sched_pkg::ST_RD_BURST : bank_sched_pkg::ST_WR_BURST;
        end
      end
      bank_sched_pkg::ST_RD_BURST,
      bank_sched_pkg::ST_WR_BURST: begin
        if (|hits) begin
          pop_o[hit_idx] = 1'b1;  // Keeps going regardless of ready
        end else begin
          state_nxt = bank_sched_pkg::ST_GAP;
        end
      end
      bank_sched_pkg::ST_GAP: begin
        state_nxt = mode_any ? bank_sched_pkg::ST_WAIT : bank_sched_pkg::ST_IDLE;
      end
      default: state_nxt = bank_sched_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= bank_sched_pkg::ST_IDLE;
      rd_last <= RD_PTR_W'(RD_FIFO_NUM - 1);  // First leader lands on queue 0
      wr_last <= WR_PTR_W'(WR_FIFO_NUM - 1);
    end else begin
      state <= state_nxt;
      if (lead_pop && (mode_i == bank_sched_pkg::MODE_RD)) begin
        rd_last <= RD_PTR_W'(lead_idx);
      end
      if (lead_pop && (mode_i == bank_sched_pkg::MODE_WR)) begin
        wr_last <= WR_PTR_W'(lead_idx - RD_FIFO_NUM);
      end
    end
  end

  // Burst tag captured from the leader head
  always_ff @(posedge clk) begin
    if (lead_pop) begin
      burst_row <= head_i[lead_idx].row;
    end
  end

endmodule

// ==== source/bank_sched_top.sv ====
//******************************
// Bank scheduling stage top
// Read and write request queues
// Write watermark and burst scheduler
// Push decode and issue mux
//******************************

module bank_sched_top #(
  parameter int RD_FIFO_NUM = 4,
  parameter int WR_FIFO_NUM = 3,
  parameter int FIFO_DEPTH  = 4,
  parameter int HI_WM       = 8,
  parameter int LO_WM       = 3
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            push_i,      // Push strobe
  input  logic [$clog2(RD_FIFO_NUM+WR_FIFO_NUM)-1:0]      push_sel_i,  // Target queue
  input  bank_sched_pkg::req_t                            push_req_i,
  input  logic                                            ready_i,     // Arbiter level
  output logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]              full_o,
  output logic                                            issue_valid_o,
  output bank_sched_pkg::req_t                            issue_req_o,
  output logic                                            issue_write_o
);

  localparam int FIFO_NUM = RD_FIFO_NUM + WR_FIFO_NUM;
  localparam int SEL_W    = $clog2(FIFO_NUM);
  localparam int CNT_W    = $clog2(FIFO_DEPTH + 1);

  logic [FIFO_NUM-1:0]                 push_vec;  // Decoded push strobes
  logic [FIFO_NUM-1:0]                 pop;       // One-hot from the scheduler
  logic [FIFO_NUM-1:0]                 empty;
  logic [FIFO_NUM-1:0][CNT_W-1:0]      cnt;
  bank_sched_pkg::req_t [FIFO_NUM-1:0] head;
  bank_sched_pkg::mode_e               mode;
  logic                                rd_pending;

  //******************************
  // Request queues
  //******************************
  for (genvar i = 0; i < FIFO_NUM; i++) begin : gen_fifo
    assign push_vec[i] = push_i && (push_sel_i == SEL_W'(i));

    req_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) req_fifo_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (push_vec[i]),
      .req_i   (push_req_i),
      .pop_i   (pop[i]),
      .head_o  (head[i]),
      .empty_o (empty[i]),
      .full_o  (full_o[i]),
      .count_o (cnt[i])
    );
  end

  // Any read queue occupied
  always_comb begin
    rd_pending = 1'b0;
    for (int i = 0; i < RD_FIFO_NUM; i++) begin
      rd_pending = rd_pending || (cnt[i] != '0);
    end
  end

  wr_watermark #(
    .WR_FIFO_NUM (WR_FIFO_NUM),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .HI_WM       (HI_WM),
    .LO_WM       (LO_WM)
  ) wr_watermark_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_count_i   (cnt[FIFO_NUM-1:RD_FIFO_NUM]),  // Write queues only
    .rd_pending_i (rd_pending),
    .mode_o       (mode)
  );

  burst_sched #(
    .RD_FIFO_NUM (RD_FIFO_NUM),
    .WR_FIFO_NUM (WR_FIFO_NUM)
  ) burst_sched_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready_i (ready_i),
    .mode_i  (mode),
    .empty_i (empty),
    .head_i  (head),
    .pop_o   (pop),
    .write_o (issue_write_o)
  );

  //******************************
  // Issue output
  //******************************
  assign issue_valid_o = |pop;  // High exactly on pop cycles

  always_comb begin
    issue_req_o = '0;
    for (int i = 0; i < FIFO_NUM; i++) begin
      if (pop[i]) begin
        issue_req_o = head[i];  // Head leaves the queue this cycle
      end
    end
  end

endmodule

// ==== verif/bank_sched_assert.sv ====
//******************************
// Concurrent assertions for the burst scheduler
// Pop vector shape, idle pops, ready gating
// Bound into every burst_sched instance
//******************************

module bank_sched_assert #(
  parameter int FIFO_NUM = 7
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         ready_i,  // Arbiter level
  input bank_sched_pkg::sched_state_e state_i,
  input logic [FIFO_NUM-1:0]          pop_i
);

  int fail_cnt = 0;  // Read by the testbench at the end

  // At most one queue pops per cycle
  a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop_i))
    else begin
      $error("Pop vector is not one-hot or zero");
      fail_cnt++;
    end

  // Idle and gap cycles never pop
  a_no_idle_pop: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i inside {bank_sched_pkg::ST_IDLE, bank_sched_pkg::ST_GAP}) |-> (pop_i == '0))
    else begin
      $error("Pop in idle or gap state");
      fail_cnt++;
    end

  // A burst leaves ST_WAIT only with the arbiter ready
  a_wait_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == bank_sched_pkg::ST_WAIT && !ready_i) |=>
    !(state_i inside {bank_sched_pkg::ST_RD_BURST, bank_sched_pkg::ST_WR_BURST}))
    else begin
      $error("Burst started from wait without ready");
      fail_cnt++;
    end

endmodule

bind burst_sched bank_sched_assert #(
  .FIFO_NUM (RD_FIFO_NUM + WR_FIFO_NUM)
) bank_sched_assert_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .ready_i (ready_i),
  .state_i (state),
  .pop_i   (pop_o)
);

// ==== verif/bank_sched_tb.sv ====
//******************************
// Testbench for the bank scheduling stage
// Clock, reset, random and directed stimulus
// Queue model with burst and watermark checks
// Watchdog sized from the stimulus length
//******************************

module bank_sched_tb;

  localparam int RD_FIFO_NUM = 4;
  localparam int WR_FIFO_NUM = 3;
  localparam int FIFO_DEPTH  = 4;
  localparam int HI_WM       = 8;
  localparam int LO_WM       = 3;
  localparam int FIFO_NUM    = RD_FIFO_NUM + WR_FIFO_NUM;
  localparam int SEL_W       = $clog2(FIFO_NUM);
  localparam int CLK_PERIOD  = 8;
  localparam int N_RAND      = 300;               // Random traffic cycles
  localparam int STIM_CYCLES = N_RAND + 60;       // Plus directed pushes
  localparam int DRAIN_MAX   = 200;               // Cycles allowed per drain

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                push_i;
  logic [SEL_W-1:0]                    push_sel_i;
  bank_sched_pkg::req_t                push_req_i;
  logic                                ready_i;
  logic [FIFO_NUM-1:0]                 full_o;
  logic                                issue_valid_o;
  bank_sched_pkg::req_t                issue_req_o;
  logic                                issue_write_o;

  bank_sched_pkg::req_t model_q [FIFO_NUM][$];  // One model queue per DUT queue
  int                   leaders[$];             // Queue of each burst leader
  int                   err_cnt = 0;
  int                   chk_cnt = 0;
  // Monitor state
  logic [FIFO_NUM-1:0]  exp_full;
  logic                 prev_valid;
  logic                 run_wr;       // Direction of the current run
  logic [bank_sched_pkg::ROW_W-1:0] run_row;
  bank_sched_pkg::req_t exp_req;
  int                   qi;
  int                   wr_occ;
  // Per test checks switched on by the directed tests
  logic                 hold_chk;     // No issue allowed
  logic                 wm_first;     // Next issue must be a write
  logic                 wm_active;    // Reads only at or below the low mark

  bank_sched_top #(
    .RD_FIFO_NUM (RD_FIFO_NUM),
    .WR_FIFO_NUM (WR_FIFO_NUM),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .HI_WM       (HI_WM),
    .LO_WM       (LO_WM)
  ) bank_sched_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (push_i),
    .push_sel_i    (push_sel_i),
    .push_req_i    (push_req_i),
    .ready_i       (ready_i),
    .full_o        (full_o),
    .issue_valid_o (issue_valid_o),
    .issue_req_o   (issue_req_o),
    .issue_write_o (issue_write_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //******************************
  // Monitor and model sampled mid cycle
  //******************************
  always @(negedge clk) begin
    if (!rst_n) begin
      prev_valid = 1'b0;
    end else begin
      wr_occ = 0;
      for (int q = 0; q < FIFO_NUM; q++) begin
        exp_full[q] = (model_q[q].size() >= FIFO_DEPTH);  // Before this edge's pop
        if (q >= RD_FIFO_NUM) begin
          wr_occ += model_q[q].size();
        end
      end
      chk_cnt++;
      if (full_o !== exp_full) begin
        $display("Fail full_o: got 0x%h expected 0x%h", full_o, exp_full);
        err_cnt++;
      end
      if (issue_valid_o) begin
        qi = int'(issue_req_o.col[2:0]);  // Column low bits carry the queue index
        chk_cnt++;
        if (hold_chk) begin
          $display("Request issued while ready_i was held low");
          err_cnt++;
        end
        if (qi >= FIFO_NUM) begin
          $display("Issued request names no queue, col 0x%h", issue_req_o.col);
          err_cnt++;
        end else if (model_q[qi].size() == 0) begin
          $display("Request issued from queue %0d which the model holds empty", qi);
          err_cnt++;
        end else begin
          exp_req = model_q[qi].pop_front();
          if (issue_req_o !== exp_req) begin
            $display("Fail issue_req_o: got 0x%h expected 0x%h", issue_req_o, exp_req);
            err_cnt++;
          end
          if (issue_write_o !== (qi >= RD_FIFO_NUM)) begin
            $display("Fail issue_write_o: got 0x%h expected 0x%h", issue_write_o,
                     (qi >= RD_FIFO_NUM));
            err_cnt++;
          end
        end
        // A run of issue cycles shares row and direction
        if (!prev_valid) begin
          run_row = issue_req_o.row;
          run_wr  = issue_write_o;
          leaders.push_back(qi);
        end else begin
          if (issue_write_o !== run_wr) begin
            $display("Fail issue_write_o in burst: got 0x%h expected 0x%h",
                     issue_write_o, run_wr);
            err_cnt++;
          end
          if (issue_req_o.row !== run_row) begin
            $display("Fail issue_req_o row in burst: got 0x%h expected 0x%h",
                     issue_req_o.row, run_row);
            err_cnt++;
          end
        end
        if (wm_first) begin
          wm_first = 1'b0;
          if (issue_write_o !== 1'b1) begin
            $display("Fail issue_write_o first after ready: got 0x%h expected 0x1",
                     issue_write_o);
            err_cnt++;
          end
        end
        if (wm_active && !issue_write_o && wr_occ > LO_WM) begin
          $display("Read issued with write occupancy %0d above the low mark", wr_occ);
          err_cnt++;
        end
      end
      prev_valid = issue_valid_o;
      if (push_i && !exp_full[push_sel_i]) begin  // Push to a full queue is dropped
        model_q[push_sel_i].push_back(push_req_i);
      end
    end
  end

  //******************************
  // Stimulus helpers
  //******************************
  task automatic apply_reset();
    rst_n     = 1'b0;
    push_i    = 1'b0;
    ready_i   = 1'b0;
    hold_chk  = 1'b0;
    wm_first  = 1'b0;
    wm_active = 1'b0;
    for (int q = 0; q < FIFO_NUM; q++) begin
      model_q[q].delete();
    end
    leaders.delete();
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  // Column holds the queue index so each issue names its queue
  function automatic bank_sched_pkg::req_t make_req(input int sel, input int row,
                                                    input int tag);
    bank_sched_pkg::req_t r;
    r.row = bank_sched_pkg::ROW_W'(row);
    r.col = {tag[0], 3'(sel)};
    return r;
  endfunction

  task automatic push_req(input int sel, input bank_sched_pkg::req_t r);
    @(posedge clk);
    #1;
    push_i     = 1'b1;
    push_sel_i = SEL_W'(sel);
    push_req_i = r;
  endtask

  task automatic idle_cycles(input int n);
    @(posedge clk);
    #1 push_i = 1'b0;
    repeat (n - 1) @(posedge clk);
  endtask

  // Ready high until the model runs dry
  task automatic drain_queues();
    int total;
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    push_i  = 1'b0;
    ready_i = 1'b1;
    do begin
      @(posedge clk);
      waited++;
      total = 0;
      for (int q = 0; q < FIFO_NUM; q++) begin
        total += model_q[q].size();
      end
    end while (total != 0 && waited < DRAIN_MAX);
    chk_cnt++;
    if (total != 0) begin
      $display("Queues did not drain in time, %0d requests left in the model", total);
      err_cnt++;
    end
    repeat (4) @(posedge clk);  // Catch any stray issue
    #1;
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  //******************************
  // Tests
  //******************************
  initial begin
    int errs;
    push_sel_i = '0;
    push_req_i = '0;
    void'($urandom(97));
    apply_reset();

    // Random traffic over a small row range for frequent row hits
    errs = err_cnt;
    for (int c = 0; c < N_RAND; c++) begin
      @(posedge clk);
      #1;
      push_i     = ($urandom % 3) != 0;
      push_sel_i = SEL_W'($urandom % FIFO_NUM);
      push_req_i = make_req(int'(push_sel_i), $urandom % 4, $urandom % 2);
      ready_i    = ($urandom % 4) != 0;
    end
    drain_queues();
    report_test("random traffic", errs);

    // Distinct rows make every round robin burst a single request
    apply_reset();
    errs = err_cnt;
    for (int k = 0; k < 2; k++) begin
      for (int q = 0; q < RD_FIFO_NUM; q++) begin
        push_req(q, make_req(q, k * 16 + q, k));
      end
    end
    idle_cycles(2);
    drain_queues();
    chk_cnt++;
    if (leaders.size() != 2 * RD_FIFO_NUM) begin
      $display("Expected %0d read bursts, saw %0d", 2 * RD_FIFO_NUM, leaders.size());
      err_cnt++;
    end else begin
      for (int i = 0; i < leaders.size(); i++) begin
        if (leaders[i] != i % RD_FIFO_NUM) begin
          $display("Fail issue_req_o leader queue: got 0x%h expected 0x%h",
                   leaders[i], i % RD_FIFO_NUM);
          err_cnt++;
        end
      end
    end
    report_test("round robin", errs);

    // Watermark test queues reads first and then writes up to the high mark
    apply_reset();
    errs = err_cnt;
    wm_active = 1'b1;
    for (int q = 0; q < RD_FIFO_NUM; q++) begin
      push_req(q, make_req(q, 5, 0));
    end
    for (int k = 0; k < HI_WM; k++) begin
      push_req(RD_FIFO_NUM + k % WR_FIFO_NUM,
               make_req(RD_FIFO_NUM + k % WR_FIFO_NUM, k % 2, k));
    end
    idle_cycles(3);  // Let the mode register settle
    wm_first = 1'b1;
    drain_queues();
    wm_active = 1'b0;
    report_test("watermark", errs);

    // Back-pressure pushes one request past the depth of two queues
    apply_reset();
    errs = err_cnt;
    hold_chk = 1'b1;
    for (int k = 0; k <= FIFO_DEPTH; k++) begin
      push_req(0, make_req(0, k, k));
      push_req(RD_FIFO_NUM + 1, make_req(RD_FIFO_NUM + 1, 9, k));
    end
    idle_cycles(4);
    chk_cnt++;
    if (model_q[0].size() != FIFO_DEPTH || full_o[0] !== 1'b1) begin
      $display("Queue 0 not held full after pushing past its depth");
      err_cnt++;
    end
    hold_chk = 1'b0;
    drain_queues();
    report_test("backpressure and full", errs);

    err_cnt += bank_sched_top_inst.burst_sched_inst.bank_sched_assert_inst.fail_cnt;
    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(STIM_CYCLES * 20 * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== bank_sched_top.f ====
source/bank_sched_pkg.sv
source/req_fifo.sv
source/wr_watermark.sv
source/burst_sched.sv
source/bank_sched_top.sv
verif/bank_sched_assert.sv
verif/bank_sched_tb.sv
